//--- common/mips_defines.svh
// word-aligned accesses only; the cache geometry macros must stay powers of two
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// ------------------------------
// data path
// ------------------------------
`define XLEN        32
// byte address without its two low bits
`define WADDR_W     30
`define REG_NUM     32

// ------------------------------
// cache geometry
// ------------------------------
`define LINE_WORDS  4
`define LINE_W      128
// word address without the word offset
`define LADDR_W     28
`define CACHE_LINES 8

`endif

//--- common/mips_pkg.sv
// standard MIPS32 encodings; andi, ori and xori take a zero-extended immediate
`include "mips_defines.svh"

package mips_pkg;

	// ------------------------------
	// instruction encodings
	// ------------------------------
	typedef enum logic [5:0] {
		OP_RTYPE = 6'b000000,
		OP_J     = 6'b000010,
		OP_BEQ   = 6'b000100,
		OP_ADDI  = 6'b001000,
		OP_SLTI  = 6'b001010,
		OP_ANDI  = 6'b001100,
		OP_ORI   = 6'b001101,
		OP_XORI  = 6'b001110,
		OP_LW    = 6'b100011,
		OP_SW    = 6'b101011
	} opcode_e;

	typedef enum logic [5:0] {
		FN_SLL = 6'b000000,
		FN_SRL = 6'b000010,
		FN_SRA = 6'b000011,
		FN_ADD = 6'b100000,
		FN_SUB = 6'b100010,
		FN_AND = 6'b100100,
		FN_OR  = 6'b100101,
		FN_XOR = 6'b100110,
		FN_NOR = 6'b100111,
		FN_SLT = 6'b101010
	} funct_e;

	typedef enum logic [3:0] {
		ALU_AND = 4'd0,
		ALU_OR  = 4'd1,
		ALU_ADD = 4'd2,
		ALU_SUB = 4'd3,
		ALU_SLT = 4'd4,
		ALU_NOR = 4'd5,
		ALU_XOR = 4'd6,
		ALU_SLL = 4'd7,
		ALU_SRA = 4'd8,
		ALU_SRL = 4'd9
	} alu_op_e;

	// ------------------------------
	// decoded controls and pipeline registers
	// ------------------------------
	typedef struct packed {
		logic reg_dst;
		logic alu_src;
		logic mem_read;
		logic mem_write;
		logic mem_to_reg;
		logic reg_write;
		logic is_branch;
		logic is_jump;
	} ctrl_t;

	typedef struct packed {
		logic [`XLEN-1:0] pc4;
		logic [`XLEN-1:0] instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t            ctrl;
		alu_op_e          alu_op;
		logic [`XLEN-1:0] op_a;
		logic [`XLEN-1:0] op_b;
		logic [`XLEN-1:0] imm;
		logic [4:0]       shamt;
		logic [4:0]       rt;
		logic [4:0]       rd;
	} id_ex_t;

	typedef struct packed {
		ctrl_t            ctrl;
		logic [`XLEN-1:0] alu_res;
		logic [`XLEN-1:0] store_data;
		logic [4:0]       dst;
	} ex_mem_t;

endpackage

//--- common/cache_bus_if.sv
// plain levels; the core holds read, write, addr and wdata unchanged while stall is high
`timescale 1ns/1ns
`include "mips_defines.svh"

interface cache_bus_if;

	logic                read;
	logic                write;
	logic [`WADDR_W-1:0] addr;
	logic [`XLEN-1:0]    wdata;
	logic                stall;
	logic [`XLEN-1:0]    rdata;

	modport core (
		output read, write, addr, wdata,
		input  stall, rdata
	);

	modport cache (
		input  read, write, addr, wdata,
		output stall, rdata
	);

endinterface

//--- cache/line_cache.sv
// rdata is valid only while stall is low; with WRITE_BACK=0 writes are dropped and never reach memory
`timescale 1ns/1ns
`include "mips_defines.svh"

module line_cache #(
	parameter int WRITE_BACK = 1
) (
	input  logic                clk,
	input  logic                rst_n,
	cache_bus_if.cache          bus,
	output logic                mem_read_o,
	output logic                mem_write_o,
	output logic [`LADDR_W-1:0] mem_addr_o,
	output logic [`LINE_W-1:0]  mem_wdata_o,
	input  logic [`LINE_W-1:0]  mem_rdata_i,
	input  logic                mem_ready_i
);

	localparam int OFF_W = $clog2(`LINE_WORDS);
	localparam int IDX_W = $clog2(`CACHE_LINES);
	localparam int TAG_W = `WADDR_W - IDX_W - OFF_W;

	// ------------------------------
	// line storage
	// ------------------------------
	logic [TAG_W-1:0]        tag_q  [`CACHE_LINES];
	logic [`LINE_W-1:0]      line_q [`CACHE_LINES];
	logic [`CACHE_LINES-1:0] valid_q;

	logic [OFF_W-1:0] off;
	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic             req;
	logic             hit;
	logic             miss;
	logic             victim_dirty;
	logic             refill;
	logic             wr_hit;

	assign off = bus.addr[OFF_W-1:0];
	assign idx = bus.addr[OFF_W +: IDX_W];
	assign tag = bus.addr[`WADDR_W-1 -: TAG_W];

	assign req  = bus.read | bus.write;
	assign hit  = valid_q[idx] && (tag_q[idx] == tag);
	assign miss = req && !hit;

	// hits are served in the same cycle
	assign bus.stall = miss;
	assign bus.rdata = line_q[idx][off*`XLEN +: `XLEN];

	assign refill = miss && !victim_dirty && mem_ready_i;
	assign wr_hit = (WRITE_BACK != 0) && bus.write && hit;

	// request drops combinationally with ready
	assign mem_read_o = miss && !victim_dirty && !mem_ready_i;
	// a dirty victim goes out under its old tag
	assign mem_addr_o = victim_dirty ? {tag_q[idx], idx} : bus.addr[`WADDR_W-1:OFF_W];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (refill) begin
			valid_q[idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (refill) begin
			tag_q[idx]  <= tag;
			line_q[idx] <= mem_rdata_i;
		end else if (wr_hit) begin
			line_q[idx][off*`XLEN +: `XLEN] <= bus.wdata;
		end
	end

	// ------------------------------
	// write-back path
	// ------------------------------
	generate
		if (WRITE_BACK != 0) begin : g_write_back
			logic [`CACHE_LINES-1:0] dirty_q;

			// dirty clears on write-back done and on refill
			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					dirty_q <= '0;
				end else if (wr_hit) begin
					dirty_q[idx] <= 1'b1;
				end else if (miss && mem_ready_i) begin
					dirty_q[idx] <= 1'b0;
				end
			end

			assign victim_dirty = valid_q[idx] && dirty_q[idx];
			assign mem_write_o  = miss && victim_dirty && !mem_ready_i;
			// word 0 sits in the low bits
			assign mem_wdata_o  = line_q[idx];
		end else begin : g_read_only
			assign victim_dirty = 1'b0;
			assign mem_write_o  = 1'b0;
			assign mem_wdata_o  = '0;
		end
	endgenerate

endmodule

//--- core/mips_decoder.sv
// unknown opcodes and function codes give all-zero controls, which act as a bubble
`timescale 1ns/1ns
`include "mips_defines.svh"

module mips_decoder (
	input  logic [`XLEN-1:0]  instr_i,
	output mips_pkg::ctrl_t   ctrl_o,
	output mips_pkg::alu_op_e alu_op_o
);

	import mips_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = instr_i[31:26];
	assign funct  = instr_i[5:0];

	always_comb begin
		ctrl_o   = '0;
		alu_op_o = ALU_ADD;
		case (opcode)
			OP_RTYPE: begin
				ctrl_o.reg_dst   = 1'b1;
				ctrl_o.reg_write = 1'b1;
				case (funct)
					FN_ADD:  alu_op_o = ALU_ADD;
					FN_SUB:  alu_op_o = ALU_SUB;
					FN_AND:  alu_op_o = ALU_AND;
					FN_OR:   alu_op_o = ALU_OR;
					FN_XOR:  alu_op_o = ALU_XOR;
					FN_NOR:  alu_op_o = ALU_NOR;
					FN_SLT:  alu_op_o = ALU_SLT;
					FN_SLL:  alu_op_o = ALU_SLL;
					FN_SRL:  alu_op_o = ALU_SRL;
					FN_SRA:  alu_op_o = ALU_SRA;
					default: ctrl_o   = '0;
				endcase
			end
			OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI: begin
				ctrl_o.alu_src   = 1'b1;
				ctrl_o.reg_write = 1'b1;
				case (opcode)
					OP_SLTI: alu_op_o = ALU_SLT;
					OP_ANDI: alu_op_o = ALU_AND;
					OP_ORI:  alu_op_o = ALU_OR;
					OP_XORI: alu_op_o = ALU_XOR;
					default: alu_op_o = ALU_ADD;
				endcase
			end
			OP_LW: begin
				ctrl_o.alu_src    = 1'b1;
				ctrl_o.mem_read   = 1'b1;
				ctrl_o.mem_to_reg = 1'b1;
				ctrl_o.reg_write  = 1'b1;
			end
			OP_SW: begin
				ctrl_o.alu_src   = 1'b1;
				ctrl_o.mem_write = 1'b1;
			end
			// resolved in decode, ALU unused
			OP_BEQ: begin
				ctrl_o.is_branch = 1'b1;
				alu_op_o         = ALU_SUB;
			end
			OP_J: begin
				ctrl_o.is_jump = 1'b1;
			end
			default: begin
				ctrl_o = '0;
			end
		endcase
	end

endmodule

//--- core/hazard_forward.sv
// forward selects are 2'b10 execute result, 2'b01 writeback value, 2'b00 register file
`timescale 1ns/1ns
`include "mips_defines.svh"

module hazard_forward (
	input  logic [$clog2(`REG_NUM)-1:0] id_rs_i,
	input  logic [$clog2(`REG_NUM)-1:0] id_rt_i,
	input  logic [$clog2(`REG_NUM)-1:0] ex_rt_i,
	input  logic [$clog2(`REG_NUM)-1:0] ex_dst_i,
	input  logic [$clog2(`REG_NUM)-1:0] mem_dst_i,
	input  logic                        ex_mem_read_i,
	input  logic                        ex_reg_write_i,
	input  logic                        mem_reg_write_i,
	output logic [1:0]                  fwd_a_o,
	output logic [1:0]                  fwd_b_o,
	output logic                        load_use_o
);

	// younger producer wins, r0 never forwards
	function automatic logic [1:0] fwd_sel(input logic [$clog2(`REG_NUM)-1:0] src);
		logic [1:0] sel;
		sel = 2'b00;
		if (ex_reg_write_i && (ex_dst_i != '0) && (ex_dst_i == src)) begin
			sel = 2'b10;
		end else if (mem_reg_write_i && (mem_dst_i != '0) && (mem_dst_i == src)) begin
			sel = 2'b01;
		end
		return sel;
	endfunction

	always_comb begin
		fwd_a_o = fwd_sel(id_rs_i);
		fwd_b_o = fwd_sel(id_rt_i);
	end

	// load data is not ready until the memory stage
	assign load_use_o = ex_mem_read_i && (ex_rt_i != '0) &&
		((ex_rt_i == id_rs_i) || (ex_rt_i == id_rt_i));

endmodule

//--- core/mips_core.sv
// no delay slot; beq and j resolve in decode and fetch assumes not taken
`timescale 1ns/1ns
`include "mips_defines.svh"

module mips_core (
	input  logic      clk,
	input  logic      rst_n,
	cache_bus_if.core ibus,
	cache_bus_if.core dbus
);

	import mips_pkg::*;

	localparam int RW = $clog2(`REG_NUM);

	logic [`XLEN-1:0] pc_q;
	logic [`XLEN-1:0] pc4;
	logic [`XLEN-1:0] pc_next;
	if_id_t           if_id_q;
	id_ex_t           id_ex_q;
	id_ex_t           id_ex_d;
	ex_mem_t          ex_mem_q;
	ex_mem_t          ex_mem_d;
	logic [`XLEN-1:0] rf_q [`REG_NUM];

	logic             fetch_q;
	logic             freeze;
	logic             load_use;
	logic             redirect;
	logic [`XLEN-1:0] instr;
	logic [RW-1:0]    rs;
	logic [RW-1:0]    rt;
	logic [RW-1:0]    rd;
	ctrl_t            ctrl_id;
	alu_op_e          alu_op_id;
	logic [1:0]       fwd_a;
	logic [1:0]       fwd_b;
	logic [`XLEN-1:0] rf_a;
	logic [`XLEN-1:0] rf_b;
	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;
	logic             logic_imm;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] br_target;
	logic [`XLEN-1:0] j_target;
	logic [RW-1:0]    ex_dst;
	logic [`XLEN-1:0] alu_b;
	logic [`XLEN-1:0] alu_res;
	logic [`XLEN-1:0] wb_data;
	logic             wb_en;

	// ------------------------------
	// fetch
	// ------------------------------
	// fetch starts one cycle after reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_q <= 1'b0;
		end else begin
			fetch_q <= 1'b1;
		end
	end

	assign freeze     = ibus.stall | dbus.stall | !fetch_q;
	assign pc4        = pc_q + 'd4;
	assign ibus.read  = fetch_q;
	assign ibus.write = 1'b0;
	assign ibus.addr  = pc_q[`XLEN-1:2];
	assign ibus.wdata = '0;

	// ------------------------------
	// decode
	// ------------------------------
	assign instr = if_id_q.instr;
	assign rs    = instr[25:21];
	assign rt    = instr[20:16];
	assign rd    = instr[15:11];

	mips_decoder u_decoder (
		.instr_i  (instr),
		.ctrl_o   (ctrl_id),
		.alu_op_o (alu_op_id)
	);

	hazard_forward u_hazard (
		.id_rs_i         (rs),
		.id_rt_i         (rt),
		.ex_rt_i         (id_ex_q.rt),
		.ex_dst_i        (ex_dst),
		.mem_dst_i       (ex_mem_q.dst),
		.ex_mem_read_i   (id_ex_q.ctrl.mem_read),
		.ex_reg_write_i  (id_ex_q.ctrl.reg_write),
		.mem_reg_write_i (ex_mem_q.ctrl.reg_write),
		.fwd_a_o         (fwd_a),
		.fwd_b_o         (fwd_b),
		.load_use_o      (load_use)
	);

	assign rf_a = (rs == '0) ? '0 : rf_q[rs];
	assign rf_b = (rt == '0) ? '0 : rf_q[rt];

	always_comb begin
		case (fwd_a)
			2'b10:   op_a = alu_res;
			2'b01:   op_a = wb_data;
			default: op_a = rf_a;
		endcase
		case (fwd_b)
			2'b10:   op_b = alu_res;
			2'b01:   op_b = wb_data;
			default: op_b = rf_b;
		endcase
	end

	// logical immediates zero-extend
	assign logic_imm = ctrl_id.alu_src &&
		(alu_op_id == ALU_AND || alu_op_id == ALU_OR || alu_op_id == ALU_XOR);
	assign imm       = logic_imm ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
	assign br_target = if_id_q.pc4 + {imm[`XLEN-3:0], 2'b00};
	assign j_target  = {if_id_q.pc4[`XLEN-1:28], instr[25:0], 2'b00};

	// operands are stale while a load-use bubble is pending
	assign redirect = !load_use && (ctrl_id.is_jump || (ctrl_id.is_branch && op_a == op_b));

	always_comb begin
		if (ctrl_id.is_jump) begin
			pc_next = j_target;
		end else if (redirect) begin
			pc_next = br_target;
		end else begin
			pc_next = pc4;
		end
	end

	always_comb begin
		id_ex_d.ctrl   = ctrl_id;
		id_ex_d.alu_op = alu_op_id;
		id_ex_d.op_a   = op_a;
		id_ex_d.op_b   = op_b;
		id_ex_d.imm    = imm;
		id_ex_d.shamt  = instr[10:6];
		id_ex_d.rt     = rt;
		id_ex_d.rd     = rd;
	end

	// ------------------------------
	// execute
	// ------------------------------
	assign ex_dst = id_ex_q.ctrl.reg_dst ? id_ex_q.rd : id_ex_q.rt;
	assign alu_b  = id_ex_q.ctrl.alu_src ? id_ex_q.imm : id_ex_q.op_b;

	// shifts act on rt
	always_comb begin
		case (id_ex_q.alu_op)
			ALU_AND: alu_res = id_ex_q.op_a & alu_b;
			ALU_OR:  alu_res = id_ex_q.op_a | alu_b;
			ALU_ADD: alu_res = id_ex_q.op_a + alu_b;
			ALU_SUB: alu_res = id_ex_q.op_a - alu_b;
			ALU_SLT: alu_res = {{(`XLEN-1){1'b0}}, $signed(id_ex_q.op_a) < $signed(alu_b)};
			ALU_NOR: alu_res = ~(id_ex_q.op_a | alu_b);
			ALU_XOR: alu_res = id_ex_q.op_a ^ alu_b;
			ALU_SLL: alu_res = alu_b << id_ex_q.shamt;
			ALU_SRL: alu_res = alu_b >> id_ex_q.shamt;
			ALU_SRA: alu_res = $signed(alu_b) >>> id_ex_q.shamt;
			default: alu_res = '0;
		endcase
	end

	always_comb begin
		ex_mem_d.ctrl       = id_ex_q.ctrl;
		ex_mem_d.alu_res    = alu_res;
		ex_mem_d.store_data = id_ex_q.op_b;
		ex_mem_d.dst        = ex_dst;
	end

	// ------------------------------
	// memory and writeback
	// ------------------------------
	assign dbus.read  = ex_mem_q.ctrl.mem_read;
	assign dbus.write = ex_mem_q.ctrl.mem_write;
	assign dbus.addr  = ex_mem_q.alu_res[`XLEN-1:2];
	assign dbus.wdata = ex_mem_q.store_data;

	assign wb_data = ex_mem_q.ctrl.mem_to_reg ? dbus.rdata : ex_mem_q.alu_res;
	assign wb_en   = ex_mem_q.ctrl.reg_write && (ex_mem_q.dst != '0) && !freeze;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_NUM; i++) begin
				rf_q[i] <= '0;
			end
		end else if (wb_en) begin
			rf_q[ex_mem_q.dst] <= wb_data;
		end
	end

	// any cache stall freezes everything
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_q     <= '0;
			if_id_q  <= '0;
			id_ex_q  <= '0;
			ex_mem_q <= '0;
		end else if (!freeze) begin
			ex_mem_q <= ex_mem_d;
			if (load_use) begin
				id_ex_q <= '0;
			end else begin
				pc_q    <= pc_next;
				id_ex_q <= id_ex_d;
				if_id_q <= redirect ? '0 : {pc4, ibus.rdata};
			end
		end
	end

endmodule

//--- rtl/mips_chip.sv
// instruction side is read-only, so it has no memory write port
`timescale 1ns/1ns
`include "mips_defines.svh"

module mips_chip (
	input  logic                clk,
	input  logic                rst_n,
	// data memory
	output logic                mem_read_D,
	output logic                mem_write_D,
	output logic [`LADDR_W-1:0] mem_addr_D,
	output logic [`LINE_W-1:0]  mem_wdata_D,
	input  logic [`LINE_W-1:0]  mem_rdata_D,
	input  logic                mem_ready_D,
	// instruction memory
	output logic                mem_read_I,
	output logic [`LADDR_W-1:0] mem_addr_I,
	input  logic [`LINE_W-1:0]  mem_rdata_I,
	input  logic                mem_ready_I,
	// copy of the data bus
	output logic [`WADDR_W-1:0] DCACHE_addr_o,
	output logic [`XLEN-1:0]    DCACHE_wdata_o,
	output logic                DCACHE_wen_o
);

	cache_bus_if i_bus ();
	cache_bus_if d_bus ();

	mips_core u_core (
		.clk   (clk),
		.rst_n (rst_n),
		.ibus  (i_bus.core),
		.dbus  (d_bus.core)
	);

	line_cache #(
		.WRITE_BACK (1)
	) d_cache (
		.clk         (clk),
		.rst_n       (rst_n),
		.bus         (d_bus.cache),
		.mem_read_o  (mem_read_D),
		.mem_write_o (mem_write_D),
		.mem_addr_o  (mem_addr_D),
		.mem_wdata_o (mem_wdata_D),
		.mem_rdata_i (mem_rdata_D),
		.mem_ready_i (mem_ready_D)
	);

	line_cache #(
		.WRITE_BACK (0)
	) i_cache (
		.clk         (clk),
		.rst_n       (rst_n),
		.bus         (i_bus.cache),
		.mem_read_o  (mem_read_I),
		.mem_write_o (),
		.mem_addr_o  (mem_addr_I),
		.mem_wdata_o (),
		.mem_rdata_i (mem_rdata_I),
		.mem_ready_i (mem_ready_I)
	);

	assign DCACHE_addr_o  = d_bus.addr;
	assign DCACHE_wdata_o = d_bus.wdata;
	assign DCACHE_wen_o   = d_bus.write;

endmodule

//--- testbench/mips_chk.sv
// expected stores belong to the fixed program in tb_mips_chip; fails[n] counts failures of test n
`timescale 1ns/1ns
`include "mips_defines.svh"

module mips_chk (
	input logic                clk,
	input logic                rst_n,
	input logic                d_read_i,
	input logic                d_write_i,
	input logic [`LADDR_W-1:0] d_addr_i,
	input logic [`LINE_W-1:0]  d_wdata_i,
	input logic                d_ready_i,
	input logic                i_read_i,
	input logic [`LADDR_W-1:0] i_addr_i,
	input logic                i_ready_i,
	input logic [`WADDR_W-1:0] st_addr_i,
	input logic [`XLEN-1:0]    st_wdata_i,
	input logic                st_wen_i
);

	localparam logic [`WADDR_W-1:0] SENTINEL = 30'h7F;
	// line of byte address 0x208, evicted by the store to 0x288
	localparam logic [`LADDR_W-1:0] WB_LINE  = 28'h20;

	int fails [1:6];
	bit seen [0:255];
	bit wb_seen;

	// ------------------------------
	// expected stores by word address
	// ------------------------------
	// bit 32 marks a store that the program makes
	function automatic logic [32:0] expected_word(input logic [`WADDR_W-1:0] wa);
		case (wa)
			30'h40:  return {1'b1, 32'h0000_0012};
			30'h41:  return {1'b1, 32'hFFFF_FFFD};
			30'h42:  return {1'b1, 32'h0000_0015};
			30'h43:  return {1'b1, 32'hFFFF_FFFD};
			30'h44:  return {1'b1, 32'hFFFF_FFE8};
			30'h45:  return {1'b1, 32'h0000_0017};
			30'h46:  return {1'b1, 32'h0000_0001};
			30'h47:  return {1'b1, 32'h0000_0150};
			30'h48:  return {1'b1, 32'h00FF_FFFF};
			30'h49:  return {1'b1, 32'hFFFF_FFFE};
			30'h4A:  return {1'b1, 32'h0000_F0F0};
			30'h4B:  return {1'b1, 32'h0000_F0FF};
			30'h4C:  return {1'b1, 32'h0000_0F00};
			30'h4D:  return {1'b1, 32'h0000_0001};
			30'h50:  return {1'b1, 32'h0000_0123};
			30'h51:  return {1'b1, 32'h0000_0246};
			30'h52:  return {1'b1, 32'h0000_0015};
			30'h53:  return {1'b1, 32'hFFFF_FFFD};
			30'h54:  return {1'b1, 32'h0000_0012};
			30'h82:  return {1'b1, 32'h0000_0015};
			30'hA2:  return {1'b1, 32'hFFFF_FFFD};
			30'h7F:  return {1'b1, 32'h0000_0000};
			default: return '0;
		endcase
	endfunction

	function automatic int test_of_addr(input logic [`WADDR_W-1:0] wa);
		if (wa >= 30'h40 && wa <= 30'h4D) return 3;
		if (wa == 30'h50 || wa == 30'h51) return 4;
		if (wa == 30'h82 || wa == 30'hA2) return 6;
		return 5;
	endfunction

	function automatic bit all_stores_seen();
		logic [32:0] e;
		for (int a = 0; a < 256; a++) begin
			e = expected_word(a[`WADDR_W-1:0]);
			if (e[32] && a != SENTINEL && !seen[a]) return 1'b0;
		end
		return 1'b1;
	endfunction

	always @(posedge clk) begin
		if (rst_n && st_wen_i && st_addr_i[`WADDR_W-1:8] == '0) begin
			seen[st_addr_i[7:0]] <= 1'b1;
		end
		if (rst_n && d_write_i && d_addr_i == WB_LINE) begin
			wb_seen <= 1'b1;
		end
	end

	// ------------------------------
	// bus rules
	// ------------------------------
	a_reset_idle: assert property (@(posedge clk)
		(!rst_n || $rose(rst_n)) |-> (!d_read_i && !d_write_i && !i_read_i && !st_wen_i))
	else begin
		fails[1]++;
		$error("memory request or store active during reset");
	end

	a_rw_exclusive: assert property (@(posedge clk) !(d_read_i && d_write_i))
	else begin
		fails[1]++;
		$error("mem_read_D and mem_write_D high together");
	end

	a_d_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(d_read_i || d_write_i) && !d_ready_i |=> $stable(d_addr_i))
	else begin
		fails[2]++;
		$error("mem_addr_D changed before mem_ready_D");
	end

	a_d_wdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
		d_write_i && !d_ready_i |=> $stable(d_wdata_i))
	else begin
		fails[2]++;
		$error("mem_wdata_D changed before mem_ready_D");
	end

	a_i_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		i_read_i && !i_ready_i |=> $stable(i_addr_i))
	else begin
		fails[2]++;
		$error("mem_addr_I changed before mem_ready_I");
	end

	// ------------------------------
	// program results
	// ------------------------------
	a_store_known: assert property (@(posedge clk) disable iff (!rst_n)
		st_wen_i |-> expected_word(st_addr_i) >= 33'h1_0000_0000)
	else begin
		fails[5]++;
		$error("store to word address %h, which the program never writes", $sampled(st_addr_i));
	end

	a_store_value: assert property (@(posedge clk) disable iff (!rst_n)
		st_wen_i && expected_word(st_addr_i) >= 33'h1_0000_0000
		|-> expected_word(st_addr_i) == {1'b1, st_wdata_i})
	else begin
		fails[test_of_addr($sampled(st_addr_i))]++;
		$error("MISMATCH DCACHE_wdata_o at %h: got %h, expected %h", $sampled(st_addr_i),
			$sampled(st_wdata_i), 32'(expected_word($sampled(st_addr_i))));
	end

	a_all_seen: assert property (@(posedge clk) disable iff (!rst_n)
		st_wen_i && st_addr_i == SENTINEL |-> all_stores_seen())
	else begin
		fails[5]++;
		$error("an expected store never reached the data cache");
	end

	a_wb_before_end: assert property (@(posedge clk) disable iff (!rst_n)
		st_wen_i && st_addr_i == SENTINEL |-> wb_seen)
	else begin
		fails[6]++;
		$error("dirty line was not written back before the sentinel store");
	end

	a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
		d_write_i && d_addr_i == WB_LINE |-> d_wdata_i[95:64] == 32'h0000_0015)
	else begin
		fails[6]++;
		$error("MISMATCH mem_wdata_D word 2: got %h, expected %h",
			$sampled(d_wdata_i[95:64]), 32'h0000_0015);
	end

endmodule

bind mips_chip mips_chk u_chk (
	.clk        (clk),
	.rst_n      (rst_n),
	.d_read_i   (mem_read_D),
	.d_write_i  (mem_write_D),
	.d_addr_i   (mem_addr_D),
	.d_wdata_i  (mem_wdata_D),
	.d_ready_i  (mem_ready_D),
	.i_read_i   (mem_read_I),
	.i_addr_i   (mem_addr_I),
	.i_ready_i  (mem_ready_I),
	.st_addr_i  (DCACHE_addr_o),
	.st_wdata_i (DCACHE_wdata_o),
	.st_wen_i   (DCACHE_wen_o)
);

//--- testbench/tb_mips_chip.sv
// program is fixed and memory latency comes from a seeded $urandom; checking is done in mips_chk
`timescale 1ns/1ns
`include "mips_defines.svh"

module tb_mips_chip;

	import mips_pkg::*;

	localparam int                  MAX_CYCLES = 5000;
	localparam logic [`WADDR_W-1:0] SENTINEL   = 30'h7F;

	logic                clk;
	logic                rst_n       = 1'b0;
	logic                mem_read_D;
	logic                mem_write_D;
	logic [`LADDR_W-1:0] mem_addr_D;
	logic [`LINE_W-1:0]  mem_wdata_D;
	logic [`LINE_W-1:0]  mem_rdata_D = '0;
	logic                mem_ready_D = 1'b0;
	logic                mem_read_I;
	logic [`LADDR_W-1:0] mem_addr_I;
	logic [`LINE_W-1:0]  mem_rdata_I = '0;
	logic                mem_ready_I = 1'b0;
	logic [`WADDR_W-1:0] DCACHE_addr_o;
	logic [`XLEN-1:0]    DCACHE_wdata_o;
	logic                DCACHE_wen_o;

	logic [`XLEN-1:0]   prog [0:63];
	logic [`LINE_W-1:0] dmem [logic [`LADDR_W-1:0]];
	int                 d_cnt;
	int                 d_wait;
	int                 i_cnt;
	int                 i_wait;
	int                 pc_idx;
	int                 total;
	int                 cycles;
	bit                 found;

	mips_chip UUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ------------------------------
	// instruction encoding
	// ------------------------------
	function automatic logic [31:0] rtype_instr(input funct_e fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		return {6'b0, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] itype_instr(input opcode_e op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jump_instr(input int target);
		return {OP_J, target[25:0]};
	endfunction

	task automatic emit(input logic [31:0] instr);
		prog[pc_idx] = instr;
		pc_idx++;
	endtask

	task automatic load_program();
		for (int i = 0; i < 64; i++) begin
			prog[i] = '0;
		end
		pc_idx = 0;
		// dependent ALU chain
		emit(itype_instr(OP_ADDI, 0, 1, 16'h0015));
		emit(itype_instr(OP_ADDI, 0, 2, 16'hFFFD));
		emit(rtype_instr(FN_ADD, 1, 2, 3, 0));
		emit(rtype_instr(FN_SUB, 3, 1, 4, 0));
		emit(rtype_instr(FN_AND, 4, 1, 5, 0));
		emit(rtype_instr(FN_OR, 5, 2, 6, 0));
		emit(rtype_instr(FN_XOR, 6, 1, 7, 0));
		emit(rtype_instr(FN_NOR, 7, 0, 8, 0));
		emit(rtype_instr(FN_SLT, 2, 1, 9, 0));
		emit(rtype_instr(FN_SLL, 0, 1, 10, 4));
		emit(rtype_instr(FN_SRL, 0, 2, 11, 8));
		emit(rtype_instr(FN_SRA, 0, 2, 12, 1));
		emit(itype_instr(OP_ANDI, 2, 13, 16'hF0F0));
		emit(itype_instr(OP_ORI, 13, 14, 16'h000F));
		emit(itype_instr(OP_XORI, 14, 15, 16'hFFFF));
		emit(itype_instr(OP_SLTI, 15, 16, 16'h0F01));
		for (int r = 3; r <= 16; r++) begin
			emit(itype_instr(OP_SW, 0, 5'(r), 16'(32'h100 + 4 * (r - 3))));
		end
		// load followed at once by its use
		emit(itype_instr(OP_ADDI, 0, 17, 16'h0123));
		emit(itype_instr(OP_SW, 0, 17, 16'h0140));
		emit(itype_instr(OP_LW, 0, 18, 16'h0140));
		emit(rtype_instr(FN_ADD, 18, 17, 19, 0));
		emit(itype_instr(OP_SW, 0, 19, 16'h0144));
		// taken beq, untaken beq, then j
		emit(itype_instr(OP_BEQ, 1, 1, 16'd2));
		emit(itype_instr(OP_SW, 0, 1, 16'h0180));
		emit(itype_instr(OP_SW, 0, 1, 16'h0184));
		emit(itype_instr(OP_SW, 0, 1, 16'h0148));
		emit(itype_instr(OP_BEQ, 1, 2, 16'd1));
		emit(itype_instr(OP_SW, 0, 2, 16'h014C));
		emit(jump_instr(pc_idx + 2));
		emit(itype_instr(OP_SW, 0, 1, 16'h0188));
		emit(itype_instr(OP_SW, 0, 3, 16'h0150));
		// same index, different tags
		emit(itype_instr(OP_SW, 0, 1, 16'h0208));
		emit(itype_instr(OP_SW, 0, 2, 16'h0288));
		emit(itype_instr(OP_SW, 0, 0, 16'h01FC));
	endtask

	// ------------------------------
	// slow memories
	// ------------------------------
	function automatic logic [`LINE_W-1:0] stored_line(input logic [`LADDR_W-1:0] la);
		logic [`LINE_W-1:0]  line;
		logic [`WADDR_W-1:0] wa;
		if (dmem.exists(la)) return dmem[la];
		for (int w = 0; w < `LINE_WORDS; w++) begin
			wa = {la, w[1:0]};
			line[w*`XLEN +: `XLEN] = {2'b00, wa} ^ 32'h5A5A_0000;
		end
		return line;
	endfunction

	function automatic logic [`LINE_W-1:0] prog_line(input logic [`LADDR_W-1:0] la);
		logic [`LINE_W-1:0] line;
		line = '0;
		if (la < 16) begin
			for (int w = 0; w < `LINE_WORDS; w++) begin
				line[w*`XLEN +: `XLEN] = prog[int'(la) * 4 + w];
			end
		end
		return line;
	endfunction

	always @(posedge clk) begin
		if (!rst_n) begin
			mem_ready_D <= 1'b0;
			d_cnt       <= 0;
			d_wait      <= $urandom % 4;
		end else if (mem_ready_D) begin
			mem_ready_D <= 1'b0;
			d_cnt       <= 0;
		end else if (mem_read_D || mem_write_D) begin
			if (d_cnt >= d_wait) begin
				mem_ready_D <= 1'b1;
				d_wait      <= $urandom % 4;
				if (mem_write_D) begin
					dmem[mem_addr_D] = mem_wdata_D;
				end else begin
					mem_rdata_D <= stored_line(mem_addr_D);
				end
			end else begin
				d_cnt <= d_cnt + 1;
			end
		end
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			mem_ready_I <= 1'b0;
			i_cnt       <= 0;
			i_wait      <= $urandom % 4;
		end else if (mem_ready_I) begin
			mem_ready_I <= 1'b0;
			i_cnt       <= 0;
		end else if (mem_read_I) begin
			if (i_cnt >= i_wait) begin
				mem_ready_I <= 1'b1;
				i_wait      <= $urandom % 4;
				mem_rdata_I <= prog_line(mem_addr_I);
			end else begin
				i_cnt <= i_cnt + 1;
			end
		end
	end

	task automatic report_test(input int num, input string name);
		int n;
		n = UUT.u_chk.fails[num];
		total += n;
		if (n == 0) begin
			$display("test %0d %s: pass", num, name);
		end else begin
			$display("test %0d %s: FAIL, %0d assertion failures", num, name, n);
		end
	endtask

	// ------------------------------
	// run
	// ------------------------------
	initial begin
		void'($urandom(32'h88475592));
		total = 0;
		found = 1'b0;
		load_program();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(negedge clk);
		report_test(1, "reset levels");

		cycles = 0;
		while (!found && cycles < MAX_CYCLES) begin
			@(negedge clk);
			cycles++;
			found = DCACHE_wen_o && (DCACHE_addr_o == SENTINEL);
		end
		if (!found) begin
			$display("timeout: no sentinel store within %0d cycles", MAX_CYCLES);
		end
		// let the assertions see the sentinel cycle
		repeat (3) @(negedge clk);

		report_test(2, "memory request stability");
		report_test(3, "alu and forwarding");
		report_test(4, "load-use stall");
		report_test(5, "control flow");
		report_test(6, "write-back");
		$display("summary: %0d assertion failures, sentinel %s after %0d cycles",
			total, found ? "reached" : "missed", cycles);
		if (total == 0 && found) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- list.f
+incdir+common
common/mips_pkg.sv
common/cache_bus_if.sv
cache/line_cache.sv
core/mips_decoder.sv
core/hazard_forward.sv
core/mips_core.sv
rtl/mips_chip.sv
testbench/mips_chk.sv
testbench/tb_mips_chip.sv

//--- Makefile
BIN  := obj_dir/Vtb_mips_chip
SRCS := $(shell grep -v '^+' list.f) common/mips_defines.svh

.PHONY: all run clean

all: run

$(BIN): list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_mips_chip -f list.f

run: $(BIN)
	$(BIN) | tee sim.log
	! grep -q "Done: errors found" sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
